/* mdu_top.f */
src/mdu_pkg.sv
src/mdu_ctrl.sv
src/mul_unit.sv
src/div_unit.sv
src/mdu_top.sv
sim/clk_gen.sv
sim/mdu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the multiply/divide unit testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f mdu_top.f --top-module mdu_tb -o mdu_sim

./obj_dir/mdu_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* sim/mdu_tb.sv */
// ==================================================
// directed and random tests of the M-extension unit
// with a reference model and error counting
// ==================================================
`timescale 1ns/1ps

module mdu_tb;
    import mdu_pkg::*;

    localparam int max_wait = 200;

    logic            clk;
    logic            rst_n;
    mdu_req_t        req;
    logic            req_valid;
    logic            req_ready;
    mdu_resp_t       resp;
    logic            resp_valid;
    logic            resp_ready;
    int              errors;
    logic [xlen-1:0] rng;

    clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mdu_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    function automatic logic [xlen-1:0] xorshift(input logic [xlen-1:0] s);
        logic [xlen-1:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // M-extension rules on 64-bit values
    function automatic logic [xlen-1:0] ref_result(input mdu_op_t op,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        r  = sa * sb;
        case (op)
            op_mulhsu: r = sa * ub;
            op_mulhu:  r = ua * ub;
            op_div, op_rem: begin
                if (b == '0) begin
                    r = (op == op_div) ? 64'hffff_ffff : ua;
                end else if (op == op_div) begin
                    r = sa / sb;
                end else begin
                    r = sa % sb;
                end
            end
            op_divu, op_remu: begin
                if (b == '0) begin
                    r = (op == op_divu) ? 64'hffff_ffff : ua;
                end else if (op == op_divu) begin
                    r = ua / ub;
                end else begin
                    r = ua % ub;
                end
            end
            default: r = sa * sb;
        endcase
        if (op == op_mulh || op == op_mulhsu || op == op_mulhu) begin
            r = r >> 32;
        end
        return r[31:0];
    endfunction

    // 0 when the divider sets the latency
    function automatic int expected_latency(input mdu_op_t op,
                                            input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
        if (!op[2]) return 3;
        if (b == '0) return 1;
        if ((op == op_div || op == op_rem) && a == 32'h8000_0000 && b == '1) return 1;
        return 0;
    endfunction

    task automatic present_req(input mdu_op_t op, input logic [xlen-1:0] a,
                               input logic [xlen-1:0] b, input logic [tag_w-1:0] rd);
        mdu_req_t r;
        r.op  = op;
        r.rs1 = a;
        r.rs2 = b;
        r.rd  = rd;
        @(posedge clk);
        req       <= r;
        req_valid <= 1'b1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            $display("timeout: request was never accepted");
            errors++;
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // cycles counted from the accepting edge
    task automatic wait_resp(output int lat);
        lat = 0;
        @(negedge clk);
        while (!resp_valid && lat < max_wait) begin
            @(negedge clk);
            lat++;
        end
        if (!resp_valid) begin
            $display("timeout: no response after an accepted request");
            errors++;
        end
    endtask

    task automatic check_resp(input mdu_op_t op, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b, input logic [tag_w-1:0] rd,
                              input int lat);
        logic [xlen-1:0] exp;
        int              exp_lat;
        exp     = ref_result(op, a, b);
        exp_lat = expected_latency(op, a, b);
        if (resp.result !== exp) begin
            $display("ERR resp.result %s a=%h b=%h: got %h expected %h",
                     op.name(), a, b, resp.result, exp);
            errors++;
        end
        if (resp.rd !== rd) begin
            $display("ERR resp.rd %s: got %h expected %h", op.name(), resp.rd, rd);
            errors++;
        end
        if (exp_lat != 0 && lat != exp_lat) begin
            $display("ERR resp_valid latency %s: got %h expected %h",
                     op.name(), lat, exp_lat);
            errors++;
        end
    endtask

    // keep resp_ready low, then take the response
    task automatic hold_and_take(input int hold);
        mdu_resp_t held;
        held = resp;
        repeat (hold) begin
            @(negedge clk);
            if (!resp_valid) begin
                $display("response was dropped while resp_ready was low");
                errors++;
            end
            if (resp !== held) begin
                $display("ERR resp while held: got %h expected %h", resp, held);
                errors++;
            end
            if (req_ready) begin
                $display("ERR req_ready while response held: got %h expected %h",
                         req_ready, 1'b0);
                errors++;
            end
        end
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);
        resp_ready <= 1'b0;
    endtask

    task automatic run_one(input mdu_op_t op, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b, input logic [tag_w-1:0] rd,
                           input int hold);
        int lat;
        present_req(op, a, b, rd);
        wait_accept();
        wait_resp(lat);
        check_resp(op, a, b, rd, lat);
        hold_and_take(hold);
    endtask

    task automatic check_after_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        if (req_ready !== 1'b1) begin
            $display("ERR req_ready after reset: got %h expected %h", req_ready, 1'b1);
            errors++;
        end
        if (resp_valid !== 1'b0) begin
            $display("ERR resp_valid after reset: got %h expected %h", resp_valid, 1'b0);
            errors++;
        end
    endtask

    task automatic mul_ops();
        logic [xlen-1:0] a_set [8] = '{32'd7, 32'hffff_fffd, 32'h8000_0000, 32'h8000_0000,
                                       32'h7fff_ffff, 32'h1234_5678, 32'hffff_ffff, 32'd0};
        logic [xlen-1:0] b_set [8] = '{32'd6, 32'd5, 32'h8000_0000, 32'hffff_ffff,
                                       32'h8000_0000, 32'hfedc_ba98, 32'hffff_ffff,
                                       32'habcd_ef01};
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                run_one(mdu_op_t'(k), a_set[i], b_set[i], 5'(i * 4 + k), 0);
            end
        end
    endtask

    // every sign pair, and divisors above the dividend
    task automatic div_ops();
        logic [xlen-1:0] a_set [8] = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c,
                                       32'd5, 32'hffff_fffb, 32'hffff_ffff, 32'd7};
        logic [xlen-1:0] b_set [8] = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9,
                                       32'd17, 32'd17, 32'd2, 32'h8000_0001};
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                run_one(mdu_op_t'(k + 4), a_set[i], b_set[i], 5'(31 - i * 4 - k), 0);
            end
        end
    endtask

    task automatic special_divides();
        logic [xlen-1:0] a_set [4] = '{32'h0000_1234, 32'h8000_0000, 32'hffff_ffff, 32'd0};
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                run_one(mdu_op_t'(k + 4), a_set[i], 32'd0, 5'(i * 4 + k), 0);
            end
        end
        // overflow only for the signed forms
        for (int k = 0; k < 4; k++) begin
            run_one(mdu_op_t'(k + 4), 32'h8000_0000, 32'hffff_ffff, 5'(20 + k), 0);
        end
    endtask

    task automatic backpressure();
        int lat;
        present_req(op_div, 32'hffff_fc19, 32'd7, 5'd9);
        wait_accept();
        wait_resp(lat);
        check_resp(op_div, 32'hffff_fc19, 32'd7, 5'd9, lat);
        // second request waits behind the held response
        present_req(op_mulhu, 32'hdead_beef, 32'h1234_5678, 5'd10);
        hold_and_take(6);
        wait_accept();
        wait_resp(lat);
        check_resp(op_mulhu, 32'hdead_beef, 32'h1234_5678, 5'd10, lat);
        hold_and_take(0);
    endtask

    task automatic random_mix();
        mdu_op_t          op;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
        logic [tag_w-1:0] rd;
        int               hold;
        logic [xlen-1:0]  ctl;
        for (int i = 0; i < 200; i++) begin
            rng  = xorshift(rng);
            ctl  = rng;
            op   = mdu_op_t'(ctl[2:0]);
            rd   = ctl[7:3];
            hold = int'(ctl[9:8]);
            rng  = xorshift(rng);
            a    = rng;
            rng  = xorshift(rng);
            b    = rng;
            // small and zero divisors now and then
            if (ctl[12:10] == 3'd0) b = b >> 28;
            if (ctl[15:13] == 3'd0) b = '0;
            run_one(op, a, b, rd, hold);
        end
    endtask

    initial begin
        repeat (200000) @(posedge clk);
        $display("run exceeded its cycle limit");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        errors     = 0;
        rng        = 32'he178_1956;
        req        <= '0;
        req_valid  <= 1'b0;
        resp_ready <= 1'b0;
        check_after_reset();
        mul_ops();
        div_ops();
        special_divides();
        backpressure();
        random_mix();
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim/clk_gen.sv */
// ==================================================
// testbench clock and reset
// ==================================================
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* src/mdu_top.sv */
// ==================================================
// M-extension execute unit: controller, multiplier
// and divider
// ==================================================
`timescale 1ns/1ps

module mdu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mdu_pkg::mdu_req_t     req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output mdu_pkg::mdu_resp_t    resp,
    output logic                  resp_valid,
    input  logic                  resp_ready
);
    import mdu_pkg::*;

    logic                mul_start;
    logic [xlen-1:0]     mul_a;
    logic [xlen-1:0]     mul_b;
    logic                mul_a_signed;
    logic                mul_b_signed;
    logic [prod_w-1:0]   mul_product;
    logic                mul_done;
    logic                div_start;
    logic [xlen-1:0]     div_dividend;
    logic [xlen-1:0]     div_divisor;
    logic                div_is_signed;
    logic [xlen-1:0]     div_quotient;
    logic [xlen-1:0]     div_remainder;
    logic                div_done;

    mdu_ctrl ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp          (resp),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .mul_start     (mul_start),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .mul_a_signed  (mul_a_signed),
        .mul_b_signed  (mul_b_signed),
        .mul_done      (mul_done),
        .mul_product   (mul_product),
        .div_start     (div_start),
        .div_dividend  (div_dividend),
        .div_divisor   (div_divisor),
        .div_is_signed (div_is_signed),
        .div_done      (div_done),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder)
    );

    mul_unit mul_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (mul_start),
        .a        (mul_a),
        .b        (mul_b),
        .a_signed (mul_a_signed),
        .b_signed (mul_b_signed),
        .product  (mul_product),
        .done     (mul_done)
    );

    div_unit div_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_is_signed),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .done      (div_done)
    );

endmodule

/* src/div_unit.sv */
// ==================================================
// radix-2 non-restoring divider with sign correction
// ==================================================
`timescale 1ns/1ps

module div_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          is_signed,
    input  logic [mdu_pkg::xlen-1:0]      dividend,
    input  logic [mdu_pkg::xlen-1:0]      divisor,
    output logic [mdu_pkg::xlen-1:0]      quotient,
    output logic [mdu_pkg::xlen-1:0]      remainder,
    output logic                          done
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_iter,
        st_fix
    } state_t;

    state_t            state_q;
    logic [xlen-1:0]   cnt_q;
    // one extra sign bit so unsigned divisors above 2^31 fit
    logic [2*xlen:0]   r_q;
    logic [xlen-1:0]   d_q;
    // 1 for a +1 digit, 0 for -1
    logic [xlen-1:0]   q_q;
    logic              dividend_neg_q;
    logic              divisor_neg_q;
    logic [2*xlen:0]   r_shift;
    logic [2*xlen:0]   d_ext;
    logic [xlen:0]     rem_fixed;
    logic [xlen-1:0]   q_bin;
    logic [xlen-1:0]   quotient_abs;
    logic [xlen-1:0]   remainder_abs;

    assign r_shift = {r_q[2*xlen-1:0], 1'b0};
    assign d_ext   = {1'b0, d_q, {xlen{1'b0}}};

    // digit set {-1,+1} to binary
    assign q_bin     = q_q - ~q_q;
    assign rem_fixed = r_q[2*xlen:xlen] + {1'b0, d_q};

    always_comb begin
        if (r_q[2*xlen]) begin
            // negative remainder, step back once
            remainder_abs = rem_fixed[xlen-1:0];
            quotient_abs  = q_bin - 1'b1;
        end else begin
            remainder_abs = r_q[2*xlen-1:xlen];
            quotient_abs  = q_bin;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start) state_q <= st_load;
                end
                st_load: begin
                    state_q <= st_iter;
                    cnt_q   <= {1'b1, {(xlen-1){1'b0}}};
                end
                st_iter: begin
                    cnt_q <= cnt_q >> 1;
                    if (cnt_q[0]) state_q <= st_fix;
                end
                st_fix: begin
                    state_q <= st_idle;
                    done    <= 1'b1;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            st_idle: begin
                if (start) begin
                    r_q            <= {{(xlen+1){1'b0}}, dividend};
                    d_q            <= divisor;
                    q_q            <= '0;
                    dividend_neg_q <= is_signed && dividend[xlen-1];
                    divisor_neg_q  <= is_signed && divisor[xlen-1];
                end
            end
            st_load: begin
                // magnitudes; -2^31 stays 2^31 unsigned
                if (dividend_neg_q) r_q[xlen-1:0] <= -r_q[xlen-1:0];
                if (divisor_neg_q) d_q <= -d_q;
            end
            st_iter: begin
                if (r_q[2*xlen]) begin
                    r_q <= r_shift + d_ext;
                    q_q <= {q_q[xlen-2:0], 1'b0};
                end else begin
                    r_q <= r_shift - d_ext;
                    q_q <= {q_q[xlen-2:0], 1'b1};
                end
            end
            st_fix: begin
                quotient  <= (dividend_neg_q ^ divisor_neg_q) ? -quotient_abs
                                                              : quotient_abs;
                // remainder follows the dividend
                remainder <= dividend_neg_q ? -remainder_abs : remainder_abs;
            end
            default: begin
                r_q <= r_q;
            end
        endcase
    end

    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state_q == st_idle);

endmodule

/* src/mul_unit.sv */
// ==================================================
// two-stage pipelined 33x33 signed multiplier
// ==================================================
`timescale 1ns/1ps

module mul_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [mdu_pkg::xlen-1:0]      a,
    input  logic [mdu_pkg::xlen-1:0]      b,
    input  logic                          a_signed,
    input  logic                          b_signed,
    output logic [mdu_pkg::prod_w-1:0]    product,
    output logic                          done
);
    import mdu_pkg::*;

    logic signed [xlen:0]     a_q;
    logic signed [xlen:0]     b_q;
    logic signed [prod_w+1:0] prod_full;
    logic [prod_w-1:0]        product_q;
    logic [1:0]               vld_q;

    // 33-bit signed operands make mulhsu a plain signed multiply
    assign prod_full = a_q * b_q;

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= {a_signed & a[xlen-1], a};
            b_q <= {b_signed & b[xlen-1], b};
        end
        if (vld_q[0]) begin
            product_q <= prod_full[prod_w-1:0];
        end
    end

    // one bit per stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 2'b00;
        end else begin
            vld_q <= {vld_q[0], start};
        end
    end

    assign product = product_q;
    assign done    = vld_q[1];

endmodule

/* src/mdu_ctrl.sv */
// ==================================================
// request decode, divide special cases, result
// selection and response holding
// ==================================================
`timescale 1ns/1ps

module mdu_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mdu_pkg::mdu_req_t             req,
    input  logic                          req_valid,
    output logic                          req_ready,
    output mdu_pkg::mdu_resp_t            resp,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic                          mul_start,
    output logic [mdu_pkg::xlen-1:0]      mul_a,
    output logic [mdu_pkg::xlen-1:0]      mul_b,
    output logic                          mul_a_signed,
    output logic                          mul_b_signed,
    input  logic                          mul_done,
    input  logic [mdu_pkg::prod_w-1:0]    mul_product,
    output logic                          div_start,
    output logic [mdu_pkg::xlen-1:0]      div_dividend,
    output logic [mdu_pkg::xlen-1:0]      div_divisor,
    output logic                          div_is_signed,
    input  logic                          div_done,
    input  logic [mdu_pkg::xlen-1:0]      div_quotient,
    input  logic [mdu_pkg::xlen-1:0]      div_remainder
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_mul,
        st_wait_div,
        st_respond
    } state_t;

    state_t          state_q;
    mdu_req_t        req_q;
    logic            zero_q;
    logic            ovf_q;
    logic            accept;
    logic            div_zero;
    logic            div_ovf;
    logic            special;
    logic            is_rem;
    logic            resp_load;
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] div_result;
    logic [xlen-1:0] special_result;
    mdu_resp_t       resp_next;

    assign req_ready  = (state_q == st_idle);
    assign resp_valid = (state_q == st_respond);
    assign accept     = req_valid && req_ready;

    // checked on the incoming request
    assign div_zero = (req.rs2 == '0);
    assign div_ovf  = (req.op == op_div || req.op == op_rem)
                   && (req.rs1 == {1'b1, {(xlen-1){1'b0}}})
                   && (req.rs2 == '1);

    // operands come from the held request
    assign mul_a         = req_q.rs1;
    assign mul_b         = req_q.rs2;
    assign mul_a_signed  = (req_q.op == op_mulh) || (req_q.op == op_mulhsu);
    assign mul_b_signed  = (req_q.op == op_mulh);
    assign div_dividend  = req_q.rs1;
    assign div_divisor   = req_q.rs2;
    assign div_is_signed = (req_q.op == op_div) || (req_q.op == op_rem);

    assign is_rem  = (req_q.op == op_rem) || (req_q.op == op_remu);
    assign special = zero_q || ovf_q;

    // low half only for mul
    assign mul_result = (req_q.op == op_mul) ? mul_product[xlen-1:0]
                                             : mul_product[prod_w-1:xlen];
    assign div_result = is_rem ? div_remainder : div_quotient;

    // x/0 -> all ones, rem x; overflow -> x, rem 0
    assign special_result = zero_q ? (is_rem ? req_q.rs1 : '1)
                                   : (is_rem ? '0 : req_q.rs1);

    always_comb begin
        resp_load        = 1'b0;
        resp_next.rd     = req_q.rd;
        resp_next.result = div_result;
        case (state_q)
            st_wait_mul: begin
                resp_load        = mul_done;
                resp_next.result = mul_result;
            end
            st_wait_div: begin
                resp_load = div_done || special;
                if (special) begin
                    resp_next.result = special_result;
                end
            end
            default: begin
                resp_load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (accept && req.op[2]) begin
                        state_q   <= st_wait_div;
                        div_start <= !(div_zero || div_ovf);
                    end else if (accept) begin
                        state_q   <= st_wait_mul;
                        mul_start <= 1'b1;
                    end
                end
                st_wait_mul: begin
                    if (mul_done) state_q <= st_respond;
                end
                st_wait_div: begin
                    if (div_done || special) state_q <= st_respond;
                end
                st_respond: begin
                    if (resp_ready) state_q <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q  <= req;
            zero_q <= div_zero;
            ovf_q  <= div_ovf;
        end
        if (resp_load) begin
            resp <= resp_next;
        end
    end

    resp_held: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

    // a unit only answers a started operation
    no_done_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == st_idle |-> !mul_done && !div_done);

endmodule

/* src/mdu_pkg.sv */
// ==================================================
// shared widths, M-extension operation codes and
// request/response types of the multiply/divide unit
// ==================================================
package mdu_pkg;

    // operand and result width
    localparam int xlen   = 32;

    // destination register number
    localparam int tag_w  = 5;

    // full product width
    localparam int prod_w = 2 * xlen;

    // funct3 order of the M extension
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } mdu_op_t;

    typedef struct packed {
        mdu_op_t          op;
        logic [xlen-1:0]  rs1;
        logic [xlen-1:0]  rs2;
        logic [tag_w-1:0] rd;
    } mdu_req_t;

    // result tagged with the request's rd
    typedef struct packed {
        logic [xlen-1:0]  result;
        logic [tag_w-1:0] rd;
    } mdu_resp_t;

endpackage
